//--- flag_pkg.sv
// ****************************************
// shared types for the flag display
// stripe boundaries are rows, exclusive; totals must fit CORDW
// ****************************************

package flag_pkg;

    localparam int CORDW     = 10;  // screen coordinate width
    localparam int N_STRIPES = 3;   // stripes from top to bottom

    // 4 bits per channel, as driven onto the vga port
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb12_t;

    // one stripe: ends at row boundary (exclusive), painted in colour
    typedef struct packed {
        logic [CORDW-1:0] boundary;
        rgb12_t           colour;
    } stripe_cfg_t;  // 22 bits

    // index 0 is the top stripe
    typedef stripe_cfg_t [N_STRIPES-1:0] stripe_bank_t;

    // bus word as seen by software vs. stripe fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [9:0]  pad;  // reads as zero, ignored on write
            stripe_cfg_t cfg;
        } fields;
    } stripe_word_u;

    // only the two codes this slave returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

//--- display_timing.sv
// ****************************************
// position counters and syncs, all outputs registered
// totals must stay below 2**CORDW; syncs active low
// ****************************************

`timescale 1ns/1ps

module display_timing #(
    parameter int H_RES  = 640,  // active columns
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_RES  = 480,  // active rows
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic                       clk_pix,
    input  logic                       reset,
    output logic [flag_pkg::CORDW-1:0] sx,
    output logic [flag_pkg::CORDW-1:0] sy,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       de,
    output logic                       frame_start
);
    import flag_pkg::*;

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;

    localparam logic [CORDW-1:0] H_LAST   = CORDW'(H_TOTAL - 1);
    localparam logic [CORDW-1:0] V_LAST   = CORDW'(V_TOTAL - 1);
    localparam logic [CORDW-1:0] H_ACT    = CORDW'(H_RES);
    localparam logic [CORDW-1:0] V_ACT    = CORDW'(V_RES);
    localparam logic [CORDW-1:0] HS_START = CORDW'(H_RES + H_FP);
    localparam logic [CORDW-1:0] HS_END   = CORDW'(H_RES + H_FP + H_SYNC);  // exclusive
    localparam logic [CORDW-1:0] VS_START = CORDW'(V_RES + V_FP);
    localparam logic [CORDW-1:0] VS_END   = CORDW'(V_RES + V_FP + V_SYNC);  // exclusive

    logic [CORDW-1:0] sx_next;
    logic [CORDW-1:0] sy_next;

    // next position; flags below are derived from it so they line up with sx/sy
    always_comb begin
        sx_next = sx + 1'b1;
        sy_next = sy;
        if (sx == H_LAST) begin  // end of line
            sx_next = '0;
            sy_next = (sy == V_LAST) ? '0 : sy + 1'b1;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx          <= '0;
            sy          <= '0;
            hsync       <= 1'b1;  // inactive
            vsync       <= 1'b1;
            de          <= 1'b1;  // 0,0 is an active pixel
            frame_start <= 1'b1;  // reset lands on the first pixel of a frame
        end else begin
            sx          <= sx_next;
            sy          <= sy_next;
            hsync       <= !(sx_next >= HS_START && sx_next < HS_END);
            vsync       <= !(sy_next >= VS_START && sy_next < VS_END);
            de          <= (sx_next < H_ACT) && (sy_next < V_ACT);
            frame_start <= (sx_next == '0) && (sy_next == '0);
        end
    end

    // counter never leaves the line
    sx_in_line: assert property (@(posedge clk_pix) disable iff (reset) sx <= H_LAST)
        else $error("sx outside horizontal total");

endmodule

//--- flag_regs.sv
// ****************************************
// axi4-lite slave, three stripe registers at 0x0/0x4/0x8
// whole-word writes only, no strobes or prot
// ****************************************

`timescale 1ns/1ps

module flag_regs #(
    parameter int V_RES = 480  // sets the reset thirds
) (
    input  logic                   clk_pix,
    input  logic                   reset,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [3:0]             awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [31:0]            wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output flag_pkg::axi_resp_t    bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [3:0]             araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [31:0]            rdata,
    output flag_pkg::axi_resp_t    rresp,
    output flag_pkg::stripe_bank_t bank
);
    import flag_pkg::*;

    // green over yellow over red, equal thirds
    localparam stripe_bank_t BANK_RESET = '{
        '{boundary: CORDW'(V_RES),         colour: '{red: 4'hE, green: 4'h1, blue: 4'h2}},
        '{boundary: CORDW'(2 * V_RES / 3), colour: '{red: 4'hF, green: 4'hE, blue: 4'h1}},
        '{boundary: CORDW'(V_RES / 3),     colour: '{red: 4'h0, green: 4'h9, blue: 4'h3}}
    };

    logic         aw_done;   // write address captured
    logic         w_done;    // write data captured
    logic [3:0]   awaddr_q;
    logic [31:0]  wdata_q;
    logic         aw_fire;
    logic         w_fire;
    logic         wr_go;     // both halves present this cycle
    logic [3:0]   wr_addr;
    logic [1:0]   wr_idx;
    logic         ar_fire;
    logic [1:0]   rd_idx;
    stripe_word_u wr_word;
    stripe_word_u rd_word;

    // word aligned and within the bank
    function automatic logic addr_ok(input logic [3:0] addr);
        return (addr[1:0] == 2'b00) && (addr[3:2] < 2'(N_STRIPES));
    endfunction

    assign awready = !aw_done && !bvalid;  // blocked while a response waits
    assign wready  = !w_done && !bvalid;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // take the channel that fires now, else the captured copy
    assign wr_addr = aw_fire ? awaddr : awaddr_q;
    assign wr_idx  = wr_addr[3:2];
    assign wr_go   = (aw_done || aw_fire) && (w_done || w_fire);

    always_comb begin
        wr_word.raw = w_fire ? wdata : wdata_q;
    end

    always_ff @(posedge clk_pix) begin
        if (aw_fire) awaddr_q <= awaddr;
        if (w_fire) wdata_q <= wdata;
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            bvalid  <= 1'b0;
        end else if (wr_go) begin
            aw_done <= 1'b0;  // ready for the next pair once b completes
            w_done  <= 1'b0;
            bvalid  <= 1'b1;
        end else begin
            aw_done <= aw_done || aw_fire;
            w_done  <= w_done || w_fire;
            if (bvalid && bready) bvalid <= 1'b0;
        end
    end

    // bank updates on the same edge that raises bvalid
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            bank <= BANK_RESET;
        end else if (wr_go && addr_ok(wr_addr)) begin
            bank[wr_idx] <= wr_word.fields.cfg;  // pad bits dropped
        end
    end

    always_ff @(posedge clk_pix) begin
        if (wr_go) bresp <= addr_ok(wr_addr) ? OKAY : SLVERR;
    end

    assign arready = !rvalid;  // one read in flight
    assign ar_fire = arvalid && arready;
    assign rd_idx  = araddr[3:2];

    always_comb begin
        rd_word.raw = '0;  // bad address reads zero
        if (addr_ok(araddr)) rd_word.fields.cfg = bank[rd_idx];
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (ar_fire) begin
            rdata <= rd_word.raw;
            rresp <= addr_ok(araddr) ? OKAY : SLVERR;
        end
    end

    // responses stay put under back-pressure
    b_hold: assert property (@(posedge clk_pix) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped before bready");

    r_hold: assert property (@(posedge clk_pix) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid dropped before rready");

endmodule

//--- flag_painter.sv
// ****************************************
// stripe colour per row, black in blanking
// config latched per frame; output one cycle behind timing
// ****************************************

`timescale 1ns/1ps

module flag_painter (
    input  logic                       clk_pix,
    input  logic                       reset,
    input  logic [flag_pkg::CORDW-1:0] sy,
    input  logic                       hsync,
    input  logic                       vsync,
    input  logic                       de,
    input  logic                       frame_start,
    input  flag_pkg::stripe_bank_t     bank,
    output logic                       vga_hsync,
    output logic                       vga_vsync,
    output flag_pkg::rgb12_t           vga_rgb
);
    import flag_pkg::*;

    stripe_bank_t shadow;   // config for the frame being drawn
    stripe_bank_t live;
    rgb12_t       paint;
    rgb12_t       display;
    logic         de_q;     // de aligned with the output register

    // reloaded only between frames so the picture never tears
    always_ff @(posedge clk_pix) begin
        if (frame_start) shadow <= bank;
    end

    // first pixel of a frame must already see the new bank
    assign live = frame_start ? bank : shadow;

    // lowest-index stripe with boundary above sy wins
    always_comb begin
        paint = live[N_STRIPES-1].colour;  // fallback is the bottom stripe
        for (int i = N_STRIPES - 1; i >= 0; i--) begin
            if (sy < live[i].boundary) paint = live[i].colour;
        end
    end

    assign display = de ? paint : rgb12_t'('0);  // blank outside the active area

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_rgb   <= '0;
            de_q      <= 1'b0;
        end else begin
            vga_hsync <= hsync;  // syncs take the same single cycle as colour
            vga_vsync <= vsync;
            vga_rgb   <= display;
            de_q      <= de;
        end
    end

    no_colour_in_blank: assert property (@(posedge clk_pix) disable iff (reset)
        !de_q |-> (vga_rgb == '0))
        else $error("colour driven during blanking");

endmodule

//--- flag_display_top.sv
// ****************************************
// vga flag with axi4-lite stripe control
// clk_pix from outside; defaults are 640x480 at 60 Hz
// ****************************************

`timescale 1ns/1ps

module flag_display_top #(
    parameter int H_RES  = 640,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_RES  = 480,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic                clk_pix,
    input  logic                reset,
    input  logic                awvalid,
    output logic                awready,
    input  logic [3:0]          awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  logic [31:0]         wdata,
    output logic                bvalid,
    input  logic                bready,
    output flag_pkg::axi_resp_t bresp,
    input  logic                arvalid,
    output logic                arready,
    input  logic [3:0]          araddr,
    output logic                rvalid,
    input  logic                rready,
    output logic [31:0]         rdata,
    output flag_pkg::axi_resp_t rresp,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output flag_pkg::rgb12_t    vga_rgb
);
    import flag_pkg::*;

    logic [CORDW-1:0] sy;           // stripes depend on row only
    logic             hsync;
    logic             vsync;
    logic             de;
    logic             frame_start;
    stripe_bank_t     bank;         // live registers, painter shadows them

    display_timing #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timing_inst (
        .clk_pix, .reset, .sx(), .sy, .hsync, .vsync, .de, .frame_start
    );

    flag_regs #(.V_RES(V_RES)) regs_inst (
        .clk_pix, .reset,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .bank
    );

    flag_painter painter_inst (
        .clk_pix, .reset, .sy, .hsync, .vsync, .de, .frame_start, .bank,
        .vga_hsync, .vga_vsync, .vga_rgb
    );

endmodule

//--- tb_clock_gen.sv
// ****************************************
// 4 ns pixel clock, reset high for 3 cycles
// ****************************************

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_pix,
    output logic reset
);
    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // 250 MHz
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk_pix);
        #1 reset = 1'b0;  // released off the edge, like all stimulus
    end

endmodule

//--- tb_flag_display.sv
// ****************************************
// 16x12 active, every porch and sync 2 wide
// pixel checker locks on the first vga_vsync fall
// ****************************************

`timescale 1ns/1ps

module tb_flag_display;
    import flag_pkg::*;

    localparam int H_RES      = 16;
    localparam int V_RES      = 12;
    localparam int PORCH      = 2;                  // front porch, sync and back porch
    localparam int H_TOTAL    = H_RES + 3 * PORCH;  // 22
    localparam int V_TOTAL    = V_RES + 3 * PORCH;  // 18
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int LIMIT      = 64;                 // cycles allowed per bus wait
    localparam int BOTH       = 0;                  // write channel orders
    localparam int ADDR_FIRST = 1;
    localparam int DATA_FIRST = 2;

    logic         clk_pix;
    logic         reset;
    logic         awvalid, wvalid, bready, arvalid, rready;
    logic         awready, wready, bvalid, arready, rvalid;
    logic [3:0]   awaddr, araddr;
    logic [31:0]  wdata, rdata;
    axi_resp_t    bresp, rresp;
    logic         vga_hsync, vga_vsync;
    rgb12_t       vga_rgb;

    stripe_bank_t reg_model;    // registers as the bus left them
    stripe_bank_t reg_prev;     // reg_model one cycle back
    stripe_bank_t frame_model;  // bank the shown frame was latched with
    int           row, col, frames_seen, hs_falls, vs_falls;
    int           errors, tests_run, tests_failed, err_mark;
    logic         locked, hs_prev, vs_prev;
    logic [31:0]  lcg_state;
    string        cur_test;

    tb_clock_gen clk_gen (.clk_pix, .reset);

    flag_display_top #(
        .H_RES(H_RES), .H_FP(PORCH), .H_SYNC(PORCH), .H_BP(PORCH),
        .V_RES(V_RES), .V_FP(PORCH), .V_SYNC(PORCH), .V_BP(PORCH)
    ) dut (.*);

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // green, yellow, red in equal thirds
    function automatic stripe_bank_t default_bank();
        stripe_bank_t b;
        b[0] = '{boundary: CORDW'(V_RES / 3), colour: '{4'h0, 4'h9, 4'h3}};
        b[1] = '{boundary: CORDW'(2 * V_RES / 3), colour: '{4'hF, 4'hE, 4'h1}};
        b[2] = '{boundary: CORDW'(V_RES), colour: '{4'hE, 4'h1, 4'h2}};
        return b;
    endfunction

    function automatic rgb12_t expected_rgb(stripe_bank_t b, int y, int x);
        if (x >= H_RES || y >= V_RES) return '0;  // blanking
        for (int i = 0; i < N_STRIPES; i++) begin
            if (y < b[i].boundary) return b[i].colour;  // first match from the top
        end
        return b[N_STRIPES-1].colour;  // nothing matched
    endfunction

    function automatic stripe_word_u word_of(stripe_cfg_t cfg);
        stripe_word_u w;
        w.raw        = '0;  // pad reads back as zero
        w.fields.cfg = cfg;
        return w;
    endfunction

    function automatic stripe_word_u random_word();
        stripe_word_u w;
        w.raw                 = next_random();  // junk in the pad bits too
        w.fields.cfg.boundary = CORDW'(next_random() % 20);  // overlaps and past the screen
        return w;
    endfunction

    task automatic check_rgb(input string what, input rgb12_t exp, input rgb12_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input stripe_word_u exp,
                              input stripe_word_u act);
        if (act.raw !== exp.raw) begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h", cur_test, what,
                     exp.raw, act.raw);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic problem(input string what);
        errors++;
        $display("%s: %s", cur_test, what);
    endtask

    task automatic finish_run();
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("%s: timed out waiting for %s", cur_test, what);
        finish_run();
    endtask

    // one clock; n counts the cycles already spent in the caller's wait
    task automatic tick(input int n, input int limit, input string what);
        @(posedge clk_pix);
        #1;
        if (n >= limit) give_up(what);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - err_mark);
        end
    endtask

    task automatic wait_frames(input int count);
        int target;
        int n;
        target = frames_seen + count;
        n      = 0;
        while (frames_seen < target) begin
            n++;
            tick(n, (count + 1) * FRAME, "frame start");
        end
    endtask

    // one write channel: valid up until ready, handshake on the next edge
    task automatic send_channel(input logic is_addr, input logic [31:0] value);
        int n;
        n = 0;
        if (is_addr) begin
            awaddr  = value[3:0];
            awvalid = 1'b1;
        end else begin
            wdata  = value;
            wvalid = 1'b1;
        end
        while (!(is_addr ? awready : wready)) begin  // ready only moves on edges
            n++;
            tick(n, LIMIT, is_addr ? "awready" : "wready");
        end
        @(posedge clk_pix);
        #1;
        if (is_addr)
            awvalid = 1'b0;
        else
            wvalid = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input stripe_word_u word,
                             input int order, input int hold, output axi_resp_t resp);
        int n;
        int i;
        if (order == BOTH) begin
            fork
                send_channel(1'b1, 32'(addr));
                send_channel(1'b0, word.raw);
            join
        end else begin
            send_channel(order == ADDR_FIRST, order == ADDR_FIRST ? 32'(addr) : word.raw);
            repeat (2) begin  // gap between the two halves
                @(posedge clk_pix);
                #1;
                if (bvalid) problem("write response before both channels arrived");
            end
            send_channel(order != ADDR_FIRST, order != ADDR_FIRST ? 32'(addr) : word.raw);
        end
        n = 0;
        while (!bvalid) begin
            n++;
            tick(n, LIMIT, "bvalid");
        end
        // register took the data on the edge that raised bvalid
        if (addr == 4'd0 || addr == 4'd4 || addr == 4'd8)
            reg_model[addr / 4] = word.fields.cfg;
        resp = bresp;
        for (i = 0; i < hold; i++) begin  // bready held low
            @(posedge clk_pix);
            #1;
            if (!bvalid || bresp !== resp) problem("write response changed before bready");
            if (awready || wready) problem("new write accepted under back-pressure");
        end
        bready = 1'b1;
        @(posedge clk_pix);
        #1;
        bready = 1'b0;
        if (bvalid) problem("bvalid stayed high after bready");
    endtask

    task automatic axi_read(input logic [3:0] addr, input int hold,
                            output stripe_word_u word, output axi_resp_t resp);
        int n;
        int i;
        n       = 0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            n++;
            tick(n, LIMIT, "arready");
        end
        @(posedge clk_pix);
        #1;
        arvalid = 1'b0;
        n       = 0;
        while (!rvalid) begin
            n++;
            tick(n, LIMIT, "rvalid");
        end
        word.raw = rdata;
        resp     = rresp;
        for (i = 0; i < hold; i++) begin  // rready held low
            @(posedge clk_pix);
            #1;
            if (!rvalid || rdata !== word.raw || rresp !== resp)
                problem("read response changed before rready");
            if (arready) problem("new read accepted under back-pressure");
        end
        rready = 1'b1;
        @(posedge clk_pix);
        #1;
        rready = 1'b0;
        if (rvalid) problem("rvalid stayed high after rready");
    endtask

    task automatic readback_all(input int hold);
        stripe_word_u got;
        axi_resp_t    resp;
        int           i;
        for (i = 0; i < N_STRIPES; i++) begin
            axi_read(4'(4 * i), hold, got, resp);
            check_resp($sformatf("read status, stripe %0d", i), OKAY, resp);
            check_word($sformatf("readback, stripe %0d", i), word_of(reg_model[i]), got);
        end
    endtask

    // follows the vga port one pixel per cycle, sampled mid-cycle
    always @(negedge clk_pix) begin
        if (reset) begin
            reg_model   = default_bank();
            reg_prev    = reg_model;
            frame_model = reg_model;
            locked      = 1'b0;
            hs_prev     = 1'b1;
            vs_prev     = 1'b1;
        end else begin
            if (locked) begin
                col = (col + 1) % H_TOTAL;
                if (col == 0) row = (row + 1) % V_TOTAL;
            end
            if (hs_prev && !vga_hsync) hs_falls++;
            if (vs_prev && !vga_vsync) begin  // falls on x=0, first row after the front porch
                vs_falls++;
                if (locked) begin
                    check_count("row at vsync fall", V_RES + PORCH, row);
                    check_count("column at vsync fall", 0, col);
                end
                row    = V_RES + PORCH;
                col    = 0;
                locked = 1'b1;
            end
            if (locked && !vs_prev && vga_vsync)
                check_count("row at vsync rise", V_RES + 2 * PORCH, row);
            if (locked && hs_prev != vga_hsync)  // low from H_RES+fp for the sync width
                check_count("column at hsync edge",
                            vga_hsync ? H_RES + 2 * PORCH : H_RES + PORCH, col);
            if (locked) begin
                if (row == 0 && col == 0) begin
                    frame_model = reg_prev;  // painter latched the bank a cycle earlier
                    frames_seen++;
                end
                check_rgb($sformatf("pixel (%0d,%0d)", col, row),
                          expected_rgb(frame_model, row, col), vga_rgb);
            end
            reg_prev = reg_model;
            hs_prev  = vga_hsync;
            vs_prev  = vga_vsync;
        end
    end

    initial begin
        stripe_word_u w;
        stripe_word_u got;
        axi_resp_t    resp;
        int           n;
        int           f0;
        int           i;
        awvalid      = 1'b0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        awaddr       = '0;
        araddr       = '0;
        wdata        = '0;
        lcg_state    = 32'he9fe_b3da;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        frames_seen  = 0;
        hs_falls     = 0;
        vs_falls     = 0;
        cur_test     = "startup";
        n            = 0;
        do begin
            n++;
            tick(n, 20, "reset release");
        end while (reset !== 1'b0);

        begin_test("reset_frame");
        wait_frames(2);  // lock, then one whole frame
        readback_all(0);
        end_test();

        begin_test("sync_timing");
        wait_frames(1);
        n  = hs_falls;
        f0 = vs_falls;
        wait_frames(1);
        check_count("hsync pulses per frame", V_TOTAL, hs_falls - n);
        check_count("vsync pulses per frame", 1, vs_falls - f0);
        end_test();

        begin_test("random_stripes");
        repeat (2) begin
            for (i = 0; i < N_STRIPES; i++) begin
                axi_write(4'(4 * i), random_word(), BOTH, 0, resp);
                check_resp("write status", OKAY, resp);
            end
            readback_all(0);
            wait_frames(2);
        end
        end_test();

        begin_test("mid_frame_write");
        n = 0;
        while (!(locked && row == V_RES / 2)) begin
            n++;
            tick(n, 2 * FRAME, "middle row");
        end
        f0                    = frames_seen;
        w.raw                 = '0;
        w.fields.cfg.boundary = CORDW'(V_RES);       // top stripe takes the whole screen
        w.fields.cfg.colour   = ~reg_model[0].colour;
        axi_write(4'd0, w, BOTH, 0, resp);
        check_resp("write status", OKAY, resp);
        check_count("frame starts during the write", f0, frames_seen);
        wait_frames(2);
        end_test();

        begin_test("bad_address");
        axi_write(4'd12, random_word(), BOTH, 0, resp);
        check_resp("write status", SLVERR, resp);
        axi_read(4'd12, 0, got, resp);
        check_resp("read status", SLVERR, resp);
        check_word("read data", word_of('0), got);
        readback_all(0);
        wait_frames(1);
        end_test();

        begin_test("handshake_order");
        axi_write(4'd0, random_word(), ADDR_FIRST, 4, resp);
        check_resp("address-first status", OKAY, resp);
        axi_write(4'd4, random_word(), DATA_FIRST, 5, resp);
        check_resp("data-first status", OKAY, resp);
        axi_write(4'd8, random_word(), BOTH, 3, resp);
        check_resp("together status", OKAY, resp);
        readback_all(4);
        wait_frames(2);
        end_test();

        finish_run();
    end

endmodule

//--- verilog.f
flag_pkg.sv
display_timing.sv
flag_regs.sv
flag_painter.sv
flag_display_top.sv
tb_clock_gen.sv
tb_flag_display.sv

//--- Bender.yml
package:
  name: flag_display

sources:
  - flag_pkg.sv
  - display_timing.sv
  - flag_regs.sv
  - flag_painter.sv
  - flag_display_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_flag_display.sv
